// ==== rtl/cpu0_host_macros.svh ====
// cpu0 host constants: LFSR seed, register view, tamper offset and trigger patterns
`ifndef CPU0_HOST_MACROS_SVH
`define CPU0_HOST_MACROS_SVH

// Program-data LFSR reset value
`define CPU0_LFSR_INIT 32'hABCD1000

// Register file size and the register shown on reg_data_o
`define CPU0_NUM_REGS 8
`define CPU0_OUT_REG 3'd0

// Added to the published address on a pattern match
`define CPU0_PC_OFFSET 13'd2

// Trigger patterns for prog_dat[13:10]
`define CPU0_TRIG_PAT_0 4'b1000
`define CPU0_TRIG_PAT_1 4'b1001
`define CPU0_TRIG_PAT_2 4'b1010
`define CPU0_TRIG_PAT_3 4'b1011
`define CPU0_TRIG_PAT_4 4'b0100
`define CPU0_TRIG_PAT_5 4'b0101
`define CPU0_TRIG_PAT_6 4'b0110
`define CPU0_TRIG_PAT_7 4'b0111
`define CPU0_TRIG_PAT_8 4'b1100
`define CPU0_TRIG_PAT_9 4'b0000

`endif

// ==== rtl/cpu0_host_pkg.sv ====
// cpu0 host types: data word, program address, register index and opcode set
package cpu0_host_pkg;

    // 16-bit data and instruction word
    typedef logic [15:0] word_t;

    // 13-bit program address
    typedef logic [12:0] pc_t;

    // Index into the eight-entry register file
    typedef logic [2:0] reg_idx_t;

    // Program-data word taken from the LFSR
    typedef logic [13:0] prog_dat_t;

    // Opcode field, instr[15:12]
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_LDI = 4'd3,  // Load zero-extended 8-bit immediate
        OP_JMP = 4'd4,
        OP_HLT = 4'd15
    } opcode_e;

endpackage

// ==== rtl/prog_data_lfsr.sv ====
// Program-data source: 32-bit Fibonacci LFSR stepped once per accepted instruction
`timescale 1ns/10ps
`include "cpu0_host_macros.svh"

module prog_data_lfsr
    import cpu0_host_pkg::*;
(
    input  logic      clk,
    input  logic      pon_rst_n_i,
    input  logic      step_i,
    output prog_dat_t prog_dat_o
);

    logic [31:0] lfsr_q;
    logic        feedback;

    // Taps 31, 21, 1, 0
    assign feedback = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            lfsr_q <= `CPU0_LFSR_INIT;
        end else if (step_i) begin
            lfsr_q <= {lfsr_q[30:0], feedback};  // Shift left, new bit at 0
        end
    end

    assign prog_dat_o = lfsr_q[13:0];

endmodule

// ==== rtl/cpu0_core.sv ====
// cpu0 core: decodes and executes one instruction per strobe on registers, PC and halt
`timescale 1ns/10ps
`include "cpu0_host_macros.svh"

module cpu0_core
    import cpu0_host_pkg::*;
(
    input  logic  clk,
    input  logic  pon_rst_n_i,
    input  word_t instr_i,
    input  logic  instr_valid_i,
    output pc_t   pc_o,
    output word_t reg_data_o,
    output logic  halt_o
);

    word_t    regs [`CPU0_NUM_REGS];
    pc_t      pc_q;
    logic     halt_q;
    word_t    reg_view_q;

    opcode_e  opcode;
    reg_idx_t rd_idx;
    reg_idx_t ra_idx;
    reg_idx_t rb_idx;
    word_t    imm_word;
    pc_t      jmp_target;
    word_t    src_a;
    word_t    src_b;

    logic     exec;
    pc_t      pc_nxt;
    logic     halt_nxt;
    logic     rf_we;
    word_t    rf_wdata;

    // Instruction fields
    assign opcode     = opcode_e'(instr_i[15:12]);
    assign rd_idx     = instr_i[11:9];
    assign ra_idx     = instr_i[8:6];
    assign rb_idx     = instr_i[5:3];
    assign imm_word   = {8'h00, instr_i[7:0]};
    assign jmp_target = instr_i[12:0];

    assign src_a = regs[ra_idx];
    assign src_b = regs[rb_idx];

    // Nothing executes once halted
    assign exec = instr_valid_i && !halt_q;

    always_comb begin
        pc_nxt   = pc_q + 13'd1;
        halt_nxt = halt_q;
        rf_we    = 1'b0;
        rf_wdata = src_a + src_b;
        case (opcode)
            OP_NOP: begin
            end
            OP_ADD: begin
                rf_we = 1'b1;
            end
            OP_SUB: begin
                rf_we    = 1'b1;
                rf_wdata = src_a - src_b;
            end
            OP_LDI: begin
                rf_we    = 1'b1;
                rf_wdata = imm_word;
            end
            OP_JMP: begin
                pc_nxt = jmp_target;
            end
            OP_HLT: begin
                pc_nxt   = pc_q;  // PC holds on halt
                halt_nxt = 1'b1;
            end
            default: begin
            end  // Undefined opcodes only advance the PC
        endcase
    end

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            pc_q   <= '0;
            halt_q <= 1'b0;
        end else if (exec) begin
            pc_q   <= pc_nxt;
            halt_q <= halt_nxt;
        end
    end

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            for (int i = 0; i < `CPU0_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (exec && rf_we) begin
            regs[rd_idx] <= rf_wdata;
        end
    end

    // Register view lags the register file by one cycle
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            reg_view_q <= '0;
        end else begin
            reg_view_q <= regs[`CPU0_OUT_REG];
        end
    end

    assign pc_o       = pc_q;
    assign reg_data_o = reg_view_q;
    assign halt_o     = halt_q;

endmodule

// ==== rtl/pc_pattern_tamper.sv ====
// Address tamper: offsets the published program address when program-data bits hit a pattern
`timescale 1ns/10ps
`include "cpu0_host_macros.svh"

module pc_pattern_tamper
    import cpu0_host_pkg::*;
(
    input  logic      clk,
    input  logic      pon_rst_n_i,
    input  prog_dat_t prog_dat_i,
    input  pc_t       pc_i,
    output pc_t       prog_adr_o
);

    localparam int NUM_PAT = 10;

    localparam logic [3:0] TRIG_PAT [NUM_PAT] = '{
        `CPU0_TRIG_PAT_0,
        `CPU0_TRIG_PAT_1,
        `CPU0_TRIG_PAT_2,
        `CPU0_TRIG_PAT_3,
        `CPU0_TRIG_PAT_4,
        `CPU0_TRIG_PAT_5,
        `CPU0_TRIG_PAT_6,
        `CPU0_TRIG_PAT_7,
        `CPU0_TRIG_PAT_8,
        `CPU0_TRIG_PAT_9
    };

    logic [3:0] sel_bits;
    logic       trig_hit;
    pc_t        adr_nxt;
    pc_t        adr_q;

    assign sel_bits = prog_dat_i[13:10];

    // Any of the ten patterns fires the trigger
    always_comb begin
        trig_hit = 1'b0;
        for (int p = 0; p < NUM_PAT; p++) begin
            if (sel_bits == TRIG_PAT[p]) begin
                trig_hit = 1'b1;
            end
        end
    end

    // Wraps modulo 2^13
    assign adr_nxt = trig_hit ? pc_i + `CPU0_PC_OFFSET : pc_i;

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            adr_q <= '0;
        end else begin
            adr_q <= adr_nxt;
        end
    end

    assign prog_adr_o = adr_q;

endmodule

// ==== rtl/cpu0_host.sv ====
// cpu0 host top: joins the program-data LFSR, the core and the address tamper block
`timescale 1ns/10ps

module cpu0_host
    import cpu0_host_pkg::*;
(
    input  logic  clk,
    input  logic  pon_rst_n_i,
    input  word_t instr_i,
    input  logic  instr_valid_i,
    output pc_t   pc_o,
    output word_t reg_data_o,
    output logic  halt_o
);

    prog_dat_t prog_dat;  // LFSR low bits
    pc_t       pc;        // Core PC before tampering

    // Steps on every strobe, halted or not
    prog_data_lfsr u_lfsr (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .step_i      (instr_valid_i),
        .prog_dat_o  (prog_dat)
    );

    cpu0_core u_core (
        .clk           (clk),
        .pon_rst_n_i   (pon_rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .pc_o          (pc),
        .reg_data_o    (reg_data_o),
        .halt_o        (halt_o)
    );

    // Registered address goes straight out as pc_o
    pc_pattern_tamper u_tamper (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .prog_dat_i  (prog_dat),
        .pc_i        (pc),
        .prog_adr_o  (pc_o)
    );

endmodule

// ==== verification/cpu0_host_model.svh ====
// cpu0 host reference model: registers, PC, halt, program-data LFSR and address tamper rule
`ifndef CPU0_HOST_MODEL_SVH
`define CPU0_HOST_MODEL_SVH

word_t       m_regs [`CPU0_NUM_REGS];
pc_t         m_pc;
logic        m_halt;
logic [31:0] m_lfsr;
pc_t         m_pc_out;   // Expected pc_o
word_t       m_reg_out;  // Expected reg_data_o
int          hit_cnt;
int          miss_cnt;

// Shift left, feedback from bits 31, 21, 1 and 0
function automatic logic [31:0] next_prog_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic pattern_hit(input logic [3:0] bits);
    case (bits)
        `CPU0_TRIG_PAT_0, `CPU0_TRIG_PAT_1, `CPU0_TRIG_PAT_2, `CPU0_TRIG_PAT_3,
        `CPU0_TRIG_PAT_4, `CPU0_TRIG_PAT_5, `CPU0_TRIG_PAT_6, `CPU0_TRIG_PAT_7,
        `CPU0_TRIG_PAT_8, `CPU0_TRIG_PAT_9: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic pc_t tamper_addr(input pc_t pc_val, input logic [31:0] lfsr_val);
    if (pattern_hit(lfsr_val[13:10])) begin
        return pc_val + `CPU0_PC_OFFSET;  // Wraps at 2^13
    end
    return pc_val;
endfunction

task automatic reset_model;
    for (int i = 0; i < `CPU0_NUM_REGS; i++) begin
        m_regs[i] = '0;
    end
    m_pc      = '0;
    m_halt    = 1'b0;
    m_lfsr    = `CPU0_LFSR_INIT;
    m_pc_out  = '0;
    m_reg_out = '0;
    hit_cnt   = 0;
    miss_cnt  = 0;
endtask

// One rising edge
task automatic step_model(input word_t ins, input logic valid);
    logic [3:0] op;
    reg_idx_t   rd;
    word_t      a;
    word_t      b;
    op = ins[15:12];
    rd = ins[11:9];
    a  = m_regs[ins[8:6]];
    b  = m_regs[ins[5:3]];
    // Published outputs see the state from before this edge
    m_pc_out  = tamper_addr(m_pc, m_lfsr);
    m_reg_out = m_regs[`CPU0_OUT_REG];
    if (valid) begin
        m_lfsr = next_prog_lfsr(m_lfsr);  // Steps even when halted
        if (pattern_hit(m_lfsr[13:10])) begin
            hit_cnt++;
        end else begin
            miss_cnt++;
        end
        if (!m_halt) begin
            case (op)
                OP_ADD: begin
                    m_regs[rd] = a + b;
                    m_pc       = m_pc + 13'd1;
                end
                OP_SUB: begin
                    m_regs[rd] = a - b;
                    m_pc       = m_pc + 13'd1;
                end
                OP_LDI: begin
                    m_regs[rd] = {8'h00, ins[7:0]};
                    m_pc       = m_pc + 13'd1;
                end
                OP_JMP: m_pc = ins[12:0];
                OP_HLT: m_halt = 1'b1;
                default: m_pc = m_pc + 13'd1;  // NOP and undefined
            endcase
        end
    end
endtask

`endif

// ==== verification/cpu0_host_tb.sv ====
// cpu0 host testbench driving a random instruction stream against a reference model
`timescale 1ns/10ps
`include "cpu0_host_macros.svh"

module cpu0_host_tb
    import cpu0_host_pkg::*;
();

    logic        clk;
    logic        pon_rst_n;
    word_t       instr;
    logic        instr_valid;
    pc_t         pc;
    word_t       reg_data;
    logic        halt;
    logic [15:0] rnd_state;

    `include "cpu0_host_model.svh"

    cpu0_host dut (
        .clk           (clk),
        .pon_rst_n_i   (pon_rst_n),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .pc_o          (pc),
        .reg_data_o    (reg_data),
        .halt_o        (halt)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (!pon_rst_n) begin
            reset_model();
        end else begin
            step_model(instr, instr_valid);
        end
    end

    // x^16 + x^15 + x^13 + x^4 + 1
    function automatic logic [15:0] next_rand_state(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            rnd_state = next_rand_state(rnd_state);  // One step per bit
            val = {val[14:0], rnd_state[0]};
        end
        return val;
    endfunction

    task automatic stop_with_failure;
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_outputs;
        check_pc("pc_o", m_pc_out, pc);
        check_word("reg_data_o", m_reg_out, reg_data);
        check_flag("halt_o", m_halt, halt);
    endtask

    function automatic word_t arith_instr();
        logic [15:0] r;
        logic [3:0]  op;
        reg_idx_t    rd;
        r = rand_bits(2);
        case (r[1:0])
            2'd1: op = OP_ADD;
            2'd2: op = OP_SUB;
            default: op = OP_LDI;
        endcase
        r  = rand_bits(4);
        rd = r[3] ? `CPU0_OUT_REG : r[2:0];  // Mostly the viewed register
        r  = rand_bits(9);
        return {op, rd, r[8:0]};
    endfunction

    function automatic word_t general_instr(input logic allow_halt);
        logic [15:0] r;
        logic [3:0]  op;
        r = rand_bits(3);
        case (r[2:0])
            3'd0: op = OP_NOP;
            3'd1: op = OP_ADD;
            3'd2: op = OP_SUB;
            3'd3: op = OP_LDI;
            3'd4: op = OP_JMP;
            3'd5: op = allow_halt ? OP_HLT : OP_JMP;
            default: begin
                r  = rand_bits(4);  // Any opcode including undefined ones
                op = r[3:0];
                if (op == OP_HLT && !allow_halt) begin
                    op = 4'd9;
                end
            end
        endcase
        r = rand_bits(12);
        return {op, r[11:0]};
    endfunction

    task automatic run_cycle(input logic valid, input word_t ins);
        @(negedge clk);
        check_outputs();
        instr_valid = valid;
        instr       = ins;
    endtask

    task automatic random_cycle(input logic arith_only, input logic allow_halt);
        logic [15:0] r;
        word_t       ins;
        r = rand_bits(2);
        if (arith_only) begin
            ins = arith_instr();
        end else begin
            ins = general_instr(allow_halt);
        end
        run_cycle(r[1:0] != 2'b00, ins);  // Strobe about three cycles in four
    endtask

    // Idle strobe must freeze both published outputs
    task automatic hold_idle(input int n);
        pc_t   held_pc;
        word_t held_reg;
        run_cycle(1'b0, '0);
        run_cycle(1'b0, '0);  // Last accepted instruction now published
        held_pc  = m_pc_out;
        held_reg = m_reg_out;
        repeat (n) begin
            run_cycle(1'b0, general_instr(1'b1));
            check_pc("pc_o", held_pc, pc);
            check_word("reg_data_o", held_reg, reg_data);
        end
    endtask

    task automatic wait_for_halt(input int limit);
        int cycles;
        cycles = 0;
        while (halt !== 1'b1 && cycles < limit) begin
            random_cycle(1'b0, 1'b1);
            cycles++;
        end
        if (halt !== 1'b1) begin
            $display("Timeout: halt_o did not rise within %0d cycles", limit);
            stop_with_failure();
        end
    endtask

    task automatic run_after_halt(input int n);
        word_t held_reg;
        held_reg = m_regs[`CPU0_OUT_REG];
        repeat (n) begin
            random_cycle(1'b0, 1'b1);
            check_word("reg_data_o", held_reg, reg_data);
            check_flag("halt_o", 1'b1, halt);
        end
    endtask

    initial begin
        pon_rst_n   = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        rnd_state   = 16'd54;
        repeat (16) begin
            @(negedge clk);
            check_pc("pc_o", '0, pc);
            check_word("reg_data_o", '0, reg_data);
            check_flag("halt_o", 1'b0, halt);
        end
        pon_rst_n = 1'b1;

        repeat (300) random_cycle(1'b1, 1'b0);
        hold_idle(8);
        repeat (400) random_cycle(1'b0, 1'b0);
        hold_idle(8);
        wait_for_halt(300);
        run_after_halt(100);
        hold_idle(4);

        $display("Trigger hits %0d, misses %0d", hit_cnt, miss_cnt);
        if (hit_cnt == 0 || miss_cnt == 0) begin
            $display("Trigger coverage incomplete: a match or a non-match never occurred");
            stop_with_failure();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== cpu0_host.f ====
+incdir+rtl
+incdir+verification
rtl/cpu0_host_pkg.sv
rtl/prog_data_lfsr.sv
rtl/cpu0_core.sv
rtl/pc_pattern_tamper.sv
rtl/cpu0_host.sv
verification/cpu0_host_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the cpu0 host testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

# Compile and run; the log decides the result
verilator --binary --timing -f cpu0_host.f --top-module cpu0_host_tb -o cpu0_host_sim \
    && ./obj_dir/cpu0_host_sim 2>&1 | tee "$log"

# Missing log or missing pass line both count as failure
[ -f "$log" ] \
    && grep -q 'All tests passed!' "$log" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
